// ==== logic/decode_pkg.sv ====
/*
 * Decode stage definitions
 * Major opcodes, micro-op encodings, operand selects and register
 * constants shared by the RV32I decode and operand gather logic
 */
package decode_pkg;

    typedef logic [31:0] instr_t;    // Encoded instruction
    typedef logic [4:0]  reg_addr_t; // Register file address

    localparam reg_addr_t REG_ZERO = 5'd0;

    // funct7 patterns for register and shift ops
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // System ops are matched on the whole word
    localparam instr_t INSTR_ECALL  = 32'h0000_0073;
    localparam instr_t INSTR_EBREAK = 32'h0010_0073;
    localparam instr_t INSTR_MRET   = 32'h3020_0073;

    // ----------------------------------------------------------------------
    // Major opcodes, instruction bits 6..0
    // ----------------------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } major_op_e;

    // ----------------------------------------------------------------------
    // Micro-op encodings, zero is always the idle op
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        LSU_NONE, LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW,
        LSU_SB, LSU_SH, LSU_SW
    } lsu_op_e;

    typedef enum logic [3:0] {
        CFU_NOP, CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU,
        CFU_JAL, CFU_ECALL, CFU_EBREAK, CFU_MRET
    } cfu_op_e;

    // Operand sources
    typedef enum logic [1:0] {OPR_A_ZERO, OPR_A_RS1, OPR_A_PC} opr_a_sel_e;
    typedef enum logic [1:0] {OPR_B_ZERO, OPR_B_RS2, OPR_B_IMM} opr_b_sel_e;
    typedef enum logic [1:0] {
        OPR_C_ZERO, OPR_C_RS2, OPR_C_IMM, OPR_C_NPC
    } opr_c_sel_e;

endpackage

// ==== logic/decode_uop_if.sv ====
/*
 * Decoded micro-op bundle
 * Ops, destination register, operand selects and immediates passed
 * from the decoder to the operand gather and the stage register
 */
interface decode_uop_if import decode_pkg::*; #(
    parameter int XLEN = 32
) ();

    alu_op_e         alu_op;
    lsu_op_e         lsu_op;
    cfu_op_e         cfu_op;
    reg_addr_t       rd;        // REG_ZERO when nothing is written
    opr_a_sel_e      opr_a_sel;
    opr_b_sel_e      opr_b_sel;
    opr_c_sel_e      opr_c_sel;
    logic [XLEN-1:0] imm_b;     // Immediate for operand B
    logic [XLEN-1:0] imm_c;     // Immediate for operand C

    modport producer (
        output alu_op, lsu_op, cfu_op, rd,
        output opr_a_sel, opr_b_sel, opr_c_sel, imm_b, imm_c
    );

    modport gather (
        input alu_op, lsu_op, cfu_op, rd,
        input opr_a_sel, opr_b_sel, opr_c_sel, imm_b, imm_c
    );

endinterface

// ==== logic/decode_uop.sv ====
/*
 * RV32I micro-op decoder
 * Maps opcode, funct3 and funct7 to ALU, LSU and CFU ops, operand
 * selects, register addresses and sign-extended immediates
 */
module decode_uop import decode_pkg::*; #(
    parameter int XLEN = 32
) (
    input  instr_t         instr_i,
    output reg_addr_t      rs1_addr_o,
    output reg_addr_t      rs2_addr_o,
    decode_uop_if.producer uop
);

    major_op_e       opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [31:0]     imm32_i;
    logic [31:0]     imm32_s;
    logic [31:0]     imm32_b;
    logic [31:0]     imm32_u;
    logic [31:0]     imm32_j;
    logic [XLEN-1:0] shamt;
    logic            legal;  // Encoding recognised
    logic            wr_rd;  // Instruction writes rd
    alu_op_e         alu_op;
    lsu_op_e         lsu_op;
    cfu_op_e         cfu_op;
    opr_a_sel_e      a_sel;
    opr_b_sel_e      b_sel;
    opr_c_sel_e      c_sel;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_c;

    function automatic logic [XLEN-1:0] sext32(input logic [31:0] value);
        return XLEN'($signed(value));
    endfunction

    assign opcode     = major_op_e'(instr_i[6:0]);
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    // ----------------------------------------------------------------------
    // Immediate formats
    // ----------------------------------------------------------------------
    assign imm32_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm32_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm32_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                      instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm32_u = {instr_i[31:12], 12'b0};
    assign imm32_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                      instr_i[20], instr_i[30:21], 1'b0};
    assign shamt   = XLEN'(instr_i[24:20]);  // Zero extended

    // ----------------------------------------------------------------------
    // Micro-op selection
    // ----------------------------------------------------------------------
    always_comb begin
        legal  = 1'b1;
        wr_rd  = 1'b0;
        alu_op = ALU_NOP;
        lsu_op = LSU_NONE;
        cfu_op = CFU_NOP;
        a_sel  = OPR_A_ZERO;
        b_sel  = OPR_B_ZERO;
        c_sel  = OPR_C_ZERO;
        imm_b  = '0;
        imm_c  = '0;
        case (opcode)
            OPC_OP: begin
                wr_rd = 1'b1;
                a_sel = OPR_A_RS1;
                b_sel = OPR_B_RS2;
                case ({funct7, funct3})
                    {FUNCT7_BASE, 3'b000}: alu_op = ALU_ADD;
                    {FUNCT7_ALT,  3'b000}: alu_op = ALU_SUB;
                    {FUNCT7_BASE, 3'b001}: alu_op = ALU_SLL;
                    {FUNCT7_BASE, 3'b010}: alu_op = ALU_SLT;
                    {FUNCT7_BASE, 3'b011}: alu_op = ALU_SLTU;
                    {FUNCT7_BASE, 3'b100}: alu_op = ALU_XOR;
                    {FUNCT7_BASE, 3'b101}: alu_op = ALU_SRL;
                    {FUNCT7_ALT,  3'b101}: alu_op = ALU_SRA;
                    {FUNCT7_BASE, 3'b110}: alu_op = ALU_OR;
                    {FUNCT7_BASE, 3'b111}: alu_op = ALU_AND;
                    default:               legal  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                wr_rd = 1'b1;
                a_sel = OPR_A_RS1;
                b_sel = OPR_B_IMM;
                imm_b = sext32(imm32_i);
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    3'b001: begin
                        alu_op = ALU_SLL;
                        imm_b  = shamt;
                        legal  = (funct7 == FUNCT7_BASE);
                    end
                    3'b101: begin
                        alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                        imm_b  = shamt;
                        legal  = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
                    end
                endcase
            end
            OPC_LOAD: begin
                wr_rd  = 1'b1;
                alu_op = ALU_ADD;  // Address = rs1 + imm
                a_sel  = OPR_A_RS1;
                b_sel  = OPR_B_IMM;
                imm_b  = sext32(imm32_i);
                case (funct3)
                    3'b000:  lsu_op = LSU_LB;
                    3'b001:  lsu_op = LSU_LH;
                    3'b010:  lsu_op = LSU_LW;
                    3'b100:  lsu_op = LSU_LBU;
                    3'b101:  lsu_op = LSU_LHU;
                    default: legal  = 1'b0;
                endcase
            end
            OPC_STORE: begin
                alu_op = ALU_ADD;
                a_sel  = OPR_A_RS1;
                b_sel  = OPR_B_IMM;
                c_sel  = OPR_C_RS2;  // Store data
                imm_b  = sext32(imm32_s);
                case (funct3)
                    3'b000:  lsu_op = LSU_SB;
                    3'b001:  lsu_op = LSU_SH;
                    3'b010:  lsu_op = LSU_SW;
                    default: legal  = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                // Compare in the ALU, C carries the branch offset
                alu_op = ALU_SUB;
                a_sel  = OPR_A_RS1;
                b_sel  = OPR_B_RS2;
                c_sel  = OPR_C_IMM;
                imm_c  = sext32(imm32_b);
                case (funct3)
                    3'b000:  cfu_op = CFU_BEQ;
                    3'b001:  cfu_op = CFU_BNE;
                    3'b100:  cfu_op = CFU_BLT;
                    3'b101:  cfu_op = CFU_BGE;
                    3'b110:  cfu_op = CFU_BLTU;
                    3'b111:  cfu_op = CFU_BGEU;
                    default: legal  = 1'b0;
                endcase
            end
            OPC_JAL: begin
                wr_rd  = 1'b1;
                cfu_op = CFU_JAL;
                a_sel  = OPR_A_PC;
                b_sel  = OPR_B_IMM;
                c_sel  = OPR_C_NPC;  // Link value
                imm_b  = sext32(imm32_j);
            end
            OPC_JALR: begin
                wr_rd  = 1'b1;
                cfu_op = CFU_JAL;
                a_sel  = OPR_A_RS1;
                b_sel  = OPR_B_IMM;
                c_sel  = OPR_C_NPC;
                imm_b  = sext32(imm32_i);
                legal  = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                wr_rd  = 1'b1;
                alu_op = ALU_OR;  // Zero OR imm
                b_sel  = OPR_B_IMM;
                imm_b  = sext32(imm32_u);
            end
            OPC_AUIPC: begin
                wr_rd  = 1'b1;
                alu_op = ALU_ADD;
                a_sel  = OPR_A_PC;
                b_sel  = OPR_B_IMM;
                c_sel  = OPR_C_IMM;
                imm_b  = sext32(imm32_u);
                imm_c  = sext32(imm32_u);
            end
            OPC_SYSTEM: begin
                case (instr_i)
                    INSTR_ECALL:  cfu_op = CFU_ECALL;
                    INSTR_EBREAK: cfu_op = CFU_EBREAK;
                    INSTR_MRET:   cfu_op = CFU_MRET;
                    default:      legal  = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // Unknown encodings leave every field at zero
    assign uop.alu_op    = legal ? alu_op : ALU_NOP;
    assign uop.lsu_op    = legal ? lsu_op : LSU_NONE;
    assign uop.cfu_op    = legal ? cfu_op : CFU_NOP;
    assign uop.rd        = (legal && wr_rd) ? instr_i[11:7] : REG_ZERO;
    assign uop.opr_a_sel = legal ? a_sel : OPR_A_ZERO;
    assign uop.opr_b_sel = legal ? b_sel : OPR_B_ZERO;
    assign uop.opr_c_sel = legal ? c_sel : OPR_C_ZERO;
    assign uop.imm_b     = legal ? imm_b : '0;
    assign uop.imm_c     = legal ? imm_c : '0;

endmodule

// ==== logic/operand_gather.sv ====
/*
 * Operand gather
 * Builds operands A, B and C from forwarded register data, PC,
 * next PC and decoded immediates
 */
module operand_gather import decode_pkg::*; #(
    parameter int XLEN = 32
) (
    decode_uop_if.gather    uop,
    input  logic [XLEN-1:0] rs1_data_i,  // Forwarded rs1
    input  logic [XLEN-1:0] rs2_data_i,  // Forwarded rs2
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] npc_i,
    output logic [XLEN-1:0] opr_a_o,
    output logic [XLEN-1:0] opr_b_o,
    output logic [XLEN-1:0] opr_c_o
);

    // Operand A, first ALU input
    always_comb begin
        case (uop.opr_a_sel)
            OPR_A_RS1: opr_a_o = rs1_data_i;
            OPR_A_PC:  opr_a_o = pc_i;
            default:   opr_a_o = '0;
        endcase
    end

    // Operand B, second ALU input
    always_comb begin
        case (uop.opr_b_sel)
            OPR_B_RS2: opr_b_o = rs2_data_i;
            OPR_B_IMM: opr_b_o = uop.imm_b;
            default:   opr_b_o = '0;
        endcase
    end

    // Operand C holds store data, branch offset or link address
    always_comb begin
        case (uop.opr_c_sel)
            OPR_C_RS2: opr_c_o = rs2_data_i;
            OPR_C_IMM: opr_c_o = uop.imm_c;
            OPR_C_NPC: opr_c_o = npc_i;
            default:   opr_c_o = '0;
        endcase
    end

endmodule

// ==== logic/decode_stage_reg.sv ====
/*
 * Decode to execute register
 * Loads the gathered micro-op when accepted, holds under back-pressure
 * and clears on flush
 */
module decode_stage_reg import decode_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            g_clk,
    input  logic            arst_n_i,
    input  logic            flush_i,     // Clears the stage to NOP
    input  logic            load_i,      // Valid and ready
    decode_uop_if.gather    uop,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] opr_a_i,
    input  logic [XLEN-1:0] opr_b_i,
    input  logic [XLEN-1:0] opr_c_i,
    output logic [XLEN-1:0] ex_pc_o,
    output logic [XLEN-1:0] ex_opr_a_o,
    output logic [XLEN-1:0] ex_opr_b_o,
    output logic [XLEN-1:0] ex_opr_c_o,
    output reg_addr_t       ex_rd_o,
    output alu_op_e         ex_alu_op_o,
    output lsu_op_e         ex_lsu_op_o,
    output cfu_op_e         ex_cfu_op_o
);

    always_ff @(posedge g_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_pc_o     <= '0;
            ex_opr_a_o  <= '0;
            ex_opr_b_o  <= '0;
            ex_opr_c_o  <= '0;
            ex_rd_o     <= REG_ZERO;
            ex_alu_op_o <= ALU_NOP;
            ex_lsu_op_o <= LSU_NONE;
            ex_cfu_op_o <= CFU_NOP;
        end else if (flush_i) begin
            // Flush wins over a same-cycle load
            ex_pc_o     <= '0;
            ex_opr_a_o  <= '0;
            ex_opr_b_o  <= '0;
            ex_opr_c_o  <= '0;
            ex_rd_o     <= REG_ZERO;
            ex_alu_op_o <= ALU_NOP;
            ex_lsu_op_o <= LSU_NONE;
            ex_cfu_op_o <= CFU_NOP;
        end else if (load_i) begin
            ex_pc_o     <= pc_i;
            ex_opr_a_o  <= opr_a_i;
            ex_opr_b_o  <= opr_b_i;
            ex_opr_c_o  <= opr_c_i;
            ex_rd_o     <= uop.rd;
            ex_alu_op_o <= uop.alu_op;
            ex_lsu_op_o <= uop.lsu_op;
            ex_cfu_op_o <= uop.cfu_op;
        end
    end

endmodule

// ==== logic/decode_stage.sv ====
/*
 * Decode and operand gather stage
 * Decodes one RV32I instruction per cycle and registers the result
 * for the execute stage
 */
module decode_stage import decode_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            g_clk,
    input  logic            arst_n_i,
    input  logic            instr_valid_i,
    input  instr_t          instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] npc_i,
    input  logic            flush_i,
    output reg_addr_t       rs1_addr_o,
    input  logic [XLEN-1:0] rs1_data_i,
    output reg_addr_t       rs2_addr_o,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic            ex_ready_i,
    output logic            eat_o,       // Instruction consumed
    output logic [XLEN-1:0] ex_pc_o,
    output logic [XLEN-1:0] ex_opr_a_o,
    output logic [XLEN-1:0] ex_opr_b_o,
    output logic [XLEN-1:0] ex_opr_c_o,
    output reg_addr_t       ex_rd_o,
    output alu_op_e         ex_alu_op_o,
    output lsu_op_e         ex_lsu_op_o,
    output cfu_op_e         ex_cfu_op_o
);

    logic            load;
    logic [XLEN-1:0] opr_a;
    logic [XLEN-1:0] opr_b;
    logic [XLEN-1:0] opr_c;

    decode_uop_if #(.XLEN(XLEN)) uop_if ();

    assign load  = instr_valid_i && ex_ready_i;
    assign eat_o = load;

    // ----------------------------------------------------------------------
    // Decode, gather and register
    // ----------------------------------------------------------------------
    decode_uop #(.XLEN(XLEN)) u_decode_uop (
        .instr_i    (instr_i),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .uop        (uop_if.producer)
    );

    operand_gather #(.XLEN(XLEN)) u_operand_gather (
        .uop        (uop_if.gather),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .pc_i       (pc_i),
        .npc_i      (npc_i),
        .opr_a_o    (opr_a),
        .opr_b_o    (opr_b),
        .opr_c_o    (opr_c)
    );

    decode_stage_reg #(.XLEN(XLEN)) u_decode_stage_reg (
        .g_clk       (g_clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .load_i      (load),
        .uop         (uop_if.gather),
        .pc_i        (pc_i),
        .opr_a_i     (opr_a),
        .opr_b_i     (opr_b),
        .opr_c_i     (opr_c),
        .ex_pc_o     (ex_pc_o),
        .ex_opr_a_o  (ex_opr_a_o),
        .ex_opr_b_o  (ex_opr_b_o),
        .ex_opr_c_o  (ex_opr_c_o),
        .ex_rd_o     (ex_rd_o),
        .ex_alu_op_o (ex_alu_op_o),
        .ex_lsu_op_o (ex_lsu_op_o),
        .ex_cfu_op_o (ex_cfu_op_o)
    );

endmodule

// ==== dv/tb_decode_stage.sv ====
/*
 * Decode stage testbench
 * Directed tests that encode RV32I instructions, drive the stage and
 * check the registered micro-op and operands against the ISA rules
 */
module tb_decode_stage;
    import decode_pkg::*;

    localparam int XLEN       = 32;
    localparam int MAX_CYCLES = 400;  // About 120 cycles of tests plus margin

    logic            g_clk;
    logic            arst_n_i;
    logic            instr_valid_i;
    instr_t          instr_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] npc_i;
    logic            flush_i;
    reg_addr_t       rs1_addr_o;
    logic [XLEN-1:0] rs1_data_i;
    reg_addr_t       rs2_addr_o;
    logic [XLEN-1:0] rs2_data_i;
    logic            ex_ready_i;
    logic            eat_o;
    logic [XLEN-1:0] ex_pc_o;
    logic [XLEN-1:0] ex_opr_a_o;
    logic [XLEN-1:0] ex_opr_b_o;
    logic [XLEN-1:0] ex_opr_c_o;
    reg_addr_t       ex_rd_o;
    alu_op_e         ex_alu_op_o;
    lsu_op_e         ex_lsu_op_o;
    cfu_op_e         ex_cfu_op_o;
    int              cycles = 0;

    decode_stage #(.XLEN(XLEN)) dut_i (.*);

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "Simulation timeout");
        end
    end

    // ----------------------------------------------------------------------
    // Instruction encoders and immediate rules
    // ----------------------------------------------------------------------
    function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Sign extend the low bits of v to XLEN
    function automatic logic [XLEN-1:0] sext(input logic [31:0] v, input int bits);
        logic [XLEN-1:0] r;
        r = '0;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = (i < bits) ? v[i] : v[bits-1];
        end
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_data(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_alu(input alu_op_e got, input alu_op_e exp);
        if (got !== exp) report_error($sformatf("alu op is %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic check_lsu(input lsu_op_e got, input lsu_op_e exp);
        if (got !== exp) report_error($sformatf("lsu op is %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic check_cfu(input cfu_op_e got, input cfu_op_e exp);
        if (got !== exp) report_error($sformatf("cfu op is %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic expect_ex(input logic [XLEN-1:0] pc, input alu_op_e alu, input lsu_op_e lsu,
                             input cfu_op_e cfu, input reg_addr_t rd, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b, input logic [XLEN-1:0] c);
        check_data("ex_pc_o", ex_pc_o, pc);
        check_alu(ex_alu_op_o, alu);
        check_lsu(ex_lsu_op_o, lsu);
        check_cfu(ex_cfu_op_o, cfu);
        check_addr("ex_rd_o", ex_rd_o, rd);
        check_data("ex_opr_a_o", ex_opr_a_o, a);
        check_data("ex_opr_b_o", ex_opr_b_o, b);
        check_data("ex_opr_c_o", ex_opr_c_o, c);
    endtask

    // Present one instruction with fresh register data and wait for eat
    task automatic issue(input instr_t instr);
        @(negedge g_clk);
        instr_i       = instr;
        rs1_data_i    = XLEN'($urandom);
        rs2_data_i    = XLEN'($urandom);
        pc_i          = XLEN'($urandom) & ~XLEN'(3);  // Word aligned
        npc_i         = pc_i + XLEN'(4);
        instr_valid_i = 1'b1;
        ex_ready_i    = 1'b1;
        @(posedge g_clk);
        while (!eat_o) @(posedge g_clk);
        check_addr("rs1_addr_o", rs1_addr_o, instr[19:15]);
        check_addr("rs2_addr_o", rs2_addr_o, instr[24:20]);
        @(negedge g_clk);
        instr_valid_i = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic test_reset();
        arst_n_i = 1'b0;
        instr_i  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP);  // Valid stays low
        repeat (2) @(posedge g_clk);
        @(negedge g_clk);
        arst_n_i = 1'b1;
        repeat (3) begin
            expect_ex('0, ALU_NOP, LSU_NONE, CFU_NOP, REG_ZERO, '0, '0, '0);
            check_bit("eat_o", eat_o, 1'b0);
            @(negedge g_clk);
        end
    endtask

    task automatic test_reg_alu();
        logic [6:0] f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        alu_op_e    ops [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                 ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
        reg_addr_t  rd;
        for (int k = 0; k < 10; k++) begin
            rd = reg_addr_t'($urandom);
            issue(enc_r(f7s[k], reg_addr_t'($urandom), reg_addr_t'($urandom), f3s[k], rd, OPC_OP));
            expect_ex(pc_i, ops[k], LSU_NONE, CFU_NOP, rd, rs1_data_i, rs2_data_i, '0);
        end
    endtask

    task automatic test_imm_alu();
        logic [2:0]  f3s [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        alu_op_e     ops [6] = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND};
        logic [6:0]  sh_f7 [3] = '{7'h00, 7'h00, 7'h20};
        logic [2:0]  sh_f3 [3] = '{3'd1, 3'd5, 3'd5};
        alu_op_e     sh_op [3] = '{ALU_SLL, ALU_SRL, ALU_SRA};
        logic [11:0] imm;
        logic [4:0]  shamt;
        logic [19:0] upper;
        reg_addr_t   rd;
        for (int k = 0; k < 6; k++) begin
            imm = 12'($urandom);
            rd  = reg_addr_t'($urandom);
            issue(enc_i(imm, reg_addr_t'($urandom), f3s[k], rd, OPC_OP_IMM));
            expect_ex(pc_i, ops[k], LSU_NONE, CFU_NOP, rd, rs1_data_i, sext(32'(imm), 12), '0);
        end
        for (int k = 0; k < 3; k++) begin
            shamt = 5'($urandom);
            rd    = reg_addr_t'($urandom);
            issue(enc_i({sh_f7[k], shamt}, reg_addr_t'($urandom), sh_f3[k], rd, OPC_OP_IMM));
            expect_ex(pc_i, sh_op[k], LSU_NONE, CFU_NOP, rd, rs1_data_i, XLEN'(shamt), '0);
        end
        upper = 20'($urandom);
        rd    = reg_addr_t'($urandom);
        issue({upper, rd, OPC_LUI});
        expect_ex(pc_i, ALU_OR, LSU_NONE, CFU_NOP, rd, '0, sext({upper, 12'b0}, 32), '0);
        upper = 20'($urandom);
        issue({upper, rd, OPC_AUIPC});
        expect_ex(pc_i, ALU_ADD, LSU_NONE, CFU_NOP, rd, pc_i,
                  sext({upper, 12'b0}, 32), sext({upper, 12'b0}, 32));
    endtask

    task automatic test_load_store();
        logic [2:0]  ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        lsu_op_e     ld_op [5] = '{LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
        logic [2:0]  st_f3 [3] = '{3'd0, 3'd1, 3'd2};
        lsu_op_e     st_op [3] = '{LSU_SB, LSU_SH, LSU_SW};
        logic [11:0] imm;
        reg_addr_t   rd;
        for (int k = 0; k < 5; k++) begin
            imm = 12'($urandom);
            rd  = reg_addr_t'($urandom);
            issue(enc_i(imm, reg_addr_t'($urandom), ld_f3[k], rd, OPC_LOAD));
            expect_ex(pc_i, ALU_ADD, ld_op[k], CFU_NOP, rd, rs1_data_i, sext(32'(imm), 12), '0);
        end
        for (int k = 0; k < 3; k++) begin
            imm = 12'($urandom);
            issue(enc_s(imm, reg_addr_t'($urandom), reg_addr_t'($urandom), st_f3[k]));
            expect_ex(pc_i, ALU_ADD, st_op[k], CFU_NOP, REG_ZERO, rs1_data_i,
                      sext(32'(imm), 12), rs2_data_i);
        end
    endtask

    task automatic test_ctrl_flow();
        logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        cfu_op_e     br_op [6] = '{CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU};
        instr_t      sys   [3] = '{32'h0000_0073, 32'h0010_0073, 32'h3020_0073};
        cfu_op_e     sys_op [3] = '{CFU_ECALL, CFU_EBREAK, CFU_MRET};
        logic [12:0] boff;
        logic [20:0] joff;
        logic [11:0] imm;
        reg_addr_t   rd;
        for (int k = 0; k < 6; k++) begin
            boff = {12'($urandom), 1'b0};
            issue(enc_b(boff, reg_addr_t'($urandom), reg_addr_t'($urandom), br_f3[k]));
            expect_ex(pc_i, ALU_SUB, LSU_NONE, br_op[k], REG_ZERO, rs1_data_i, rs2_data_i,
                      sext(32'(boff), 13));
        end
        joff = {20'($urandom), 1'b0};
        rd   = reg_addr_t'($urandom);
        issue(enc_j(joff, rd));
        expect_ex(pc_i, ALU_NOP, LSU_NONE, CFU_JAL, rd, pc_i, sext(32'(joff), 21), npc_i);
        imm = 12'($urandom);
        issue(enc_i(imm, reg_addr_t'($urandom), 3'd0, rd, OPC_JALR));
        expect_ex(pc_i, ALU_NOP, LSU_NONE, CFU_JAL, rd, rs1_data_i, sext(32'(imm), 12), npc_i);
        for (int k = 0; k < 3; k++) begin
            issue(sys[k]);
            expect_ex(pc_i, ALU_NOP, LSU_NONE, sys_op[k], REG_ZERO, '0, '0, '0);
        end
    endtask

    task automatic test_backpressure_flush();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        reg_addr_t       rd;
        rd = reg_addr_t'($urandom);
        issue(enc_r(7'h00, 5'd3, 5'd4, 3'd4, rd, OPC_OP));  // XOR
        pc = pc_i;
        a  = rs1_data_i;
        b  = rs2_data_i;
        expect_ex(pc, ALU_XOR, LSU_NONE, CFU_NOP, rd, a, b, '0);
        // SUB offered while execute is stalled
        instr_i       = enc_r(7'h20, 5'd5, 5'd6, 3'd0, 5'd7, OPC_OP);
        rs1_data_i    = XLEN'($urandom);
        pc_i          = pc + XLEN'(4);
        instr_valid_i = 1'b1;
        ex_ready_i    = 1'b0;
        repeat (3) begin
            @(posedge g_clk);
            check_bit("eat_o", eat_o, 1'b0);
            @(negedge g_clk);
            expect_ex(pc, ALU_XOR, LSU_NONE, CFU_NOP, rd, a, b, '0);
        end
        flush_i       = 1'b1;
        instr_valid_i = 1'b0;
        ex_ready_i    = 1'b1;
        @(negedge g_clk);
        flush_i = 1'b0;
        expect_ex('0, ALU_NOP, LSU_NONE, CFU_NOP, REG_ZERO, '0, '0, '0);
        issue(32'hdead_beff);  // Opcode 7'h7f is not RV32I
        expect_ex(pc_i, ALU_NOP, LSU_NONE, CFU_NOP, REG_ZERO, '0, '0, '0);
    endtask

    initial begin
        void'($urandom(32'h06dd7e40));
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        npc_i         = '0;
        flush_i       = 1'b0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        ex_ready_i    = 1'b1;
        test_reset();
        test_reg_alu();
        test_imm_alu();
        test_load_store();
        test_ctrl_flow();
        test_backpressure_flush();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/decode_pkg.sv
logic/decode_uop_if.sv
logic/decode_uop.sv
logic/operand_gather.sv
logic/decode_stage_reg.sv
logic/decode_stage.sv
dv/tb_decode_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_decode_stage -f verilog.f \
    -o tb_decode_stage || { echo "Build failed"; exit 1; }

./obj_dir/tb_decode_stage > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
